//--- build.f
+incdir+rtl
rtl/tcdm_req_pkg.sv
rtl/tcdm_resp_pkg.sv
rtl/rr_arbiter.sv
rtl/tcdm_xbar.sv
rtl/tcdm_interconnect.sv
rtl/tcdm_bank.sv
rtl/tcdm_subsystem.sv
tb/tb_clkgen.sv
tb/tcdm_sva.sv
tb/tb_top.sv

//--- run.sh
#!/bin/sh
# Compile the TCDM testbench with Verilator and run it.
# The exit status of the simulation is the result of the run.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module tb_top \
  -f build.f

./obj_dir/Vtb_top

//--- tb/tcdm_vectors.txt
# batch initiator op(0 read, 1 write) addr be wdata expected_rdata
# all lines of one batch are issued together, one per initiator
# values in hex except batch, initiator and op
0 0 1 0000 f 11111111 00000000
0 1 1 0004 f 22222222 00000000
0 2 1 0008 f 33333333 00000000
0 3 1 000c f 44444444 00000000
1 0 1 0014 f 55555555 00000000
1 1 1 0018 f 66666666 00000000
1 2 1 001c f 77777777 00000000
1 3 1 0010 f 88888888 00000000
2 0 0 0000 0 00000000 11111111
2 1 0 0004 0 00000000 22222222
2 2 0 0008 0 00000000 33333333
2 3 0 000c 0 00000000 44444444
3 0 0 0004 0 00000000 22222222
3 1 0 0008 0 00000000 33333333
3 2 0 000c 0 00000000 44444444
3 3 0 0000 0 00000000 11111111
4 0 0 0008 0 00000000 33333333
4 1 0 000c 0 00000000 44444444
4 2 0 0000 0 00000000 11111111
4 3 0 0004 0 00000000 22222222
5 0 0 000c 0 00000000 44444444
5 1 0 0000 0 00000000 11111111
5 2 0 0004 0 00000000 22222222
5 3 0 0008 0 00000000 33333333
6 0 1 0000 3 0000beef 00000000
6 1 0 0010 0 00000000 88888888
6 3 1 0014 c cafe0000 00000000
7 0 0 0014 0 00000000 cafe5555
7 1 0 0000 0 00000000 1111beef
7 2 0 0010 0 00000000 88888888
8 0 0 0008 0 00000000 33333333
8 1 0 0018 0 00000000 66666666
8 2 0 0008 0 00000000 33333333
8 3 0 0018 0 00000000 66666666
9 0 0 000c 0 00000000 44444444
9 1 0 001c 0 00000000 77777777
9 2 0 000c 0 00000000 44444444
9 3 0 001c 0 00000000 77777777
10 0 1 0004 f 9999aaaa 00000000
10 1 1 0014 f bbbbcccc 00000000
10 2 1 0024 f ddddeeee 00000000
10 3 1 0034 f 12345678 00000000
11 0 0 0034 0 00000000 12345678
11 1 0 0014 0 00000000 bbbbcccc
11 2 0 0004 0 00000000 9999aaaa
11 3 0 0024 0 00000000 ddddeeee

//--- tb/tb_top.sv
/*
  Testbench top for the shared TCDM.
  Runs the directed batches from the vectors file, fills the memory,
  then issues random batches. Grants, responses and read data are
  checked every cycle against a model of the banks and arbiters.
*/
`timescale 1ns/1ns
`include "tcdm_config.svh"

module tb_top
  import tcdm_req_pkg::*;
  import tcdm_resp_pkg::*;
();

  localparam int NumIn       = `TCDM_NUM_IN;
  localparam int NumOut      = `TCDM_NUM_OUT;
  localparam int NumWords    = NumOut * (2**`TCDM_ADDR_MEM_WIDTH);
  localparam int AddrW       = `TCDM_ADDR_WIDTH;
  localparam int MaxLines    = 128;
  localparam int RandBatches = 200;
  localparam int ResetCycles = 16;
  localparam logic [NumIn-1:0] RespOn = `TCDM_WRITE_RESP_ON;

  logic                         clk;
  logic                         rst;
  logic    [NumIn-1:0]          req;
  logic    [NumIn-1:0][AddrW-1:0] addr;
  logic    [NumIn-1:0]          wen;
  word_t   [NumIn-1:0]          wdata;
  byteEn_t [NumIn-1:0]          be;
  logic    [NumIn-1:0]          gnt;
  logic    [NumIn-1:0]          vld;
  word_t   [NumIn-1:0]          rdata;

  // vectors from file
  int             vBatch [MaxLines];
  int             vInit  [MaxLines];
  int             vOp    [MaxLines];
  logic [AddrW-1:0] vAddr [MaxLines];
  byteEn_t        vBe    [MaxLines];
  word_t          vData  [MaxLines];
  word_t          vExp   [MaxLines];
  int             nLines;

  // one outstanding transaction per initiator
  bit             pend     [NumIn];
  bit             slotWen  [NumIn];
  logic [AddrW-1:0] slotAddr [NumIn];
  byteEn_t        slotBe   [NumIn];
  word_t          slotData [NumIn];
  word_t          slotExp  [NumIn];
  bit             slotFile [NumIn];

  // reference state
  int             rrPtr    [NumOut];
  bit             bankBusy [NumOut];
  word_t          refMem   [NumWords];
  bit             prevGnt  [NumIn];
  bit             prevWen  [NumIn];
  word_t          prevExp  [NumIn];

  int unsigned    lcgState;
  int             cycles;
  int             cycleLimit;

  tb_clkgen #(.PeriodNs(20), .ResetCycles(ResetCycles)) i_tb_clkgen (
    .clk_o ( clk ),
    .rst_o ( rst )
  );

  tcdm_subsystem tcdm_subsystem_i (
    .clk_i   ( clk   ),
    .rst_i   ( rst   ),
    .req_i   ( req   ),
    .addr_i  ( addr  ),
    .wen_i   ( wen   ),
    .wdata_i ( wdata ),
    .be_i    ( be    ),
    .gnt_o   ( gnt   ),
    .vld_o   ( vld   ),
    .rdata_o ( rdata )
  );

  bind tcdm_xbar tcdm_sva i_tcdm_sva (
    .clk_i      ( clk_i     ),
    .rst_i      ( rst_i     ),
    .initGnt_i  ( gnt_o     ),
    .bankSel_i  ( bankSel_i ),
    .bankReq_i  ( req_o     ),
    .bankAck_i  ( gnt_i     ),
    .bankData_i ( data_o    ),
    .vld_i      ( vld_o     )
  );

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // word interleaving, bank in the low word bits
  function automatic int wordOf(input logic [AddrW-1:0] a);
    return int'(a >> 2) % NumWords;
  endfunction

  function automatic int bankOf(input logic [AddrW-1:0] a);
    return int'(a >> 2) % NumOut;
  endfunction

  function automatic word_t mergeBytes(input word_t old, input word_t nw, input byteEn_t e);
    word_t r;
    r = old;
    for (int b = 0; b < $bits(byteEn_t); b++) begin
      if (e[b]) begin
        r[8*b +: 8] = nw[8*b +: 8];
      end
    end
    return r;
  endfunction

  function automatic int unsigned nextRand();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState >> 8;
  endfunction

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      $display("Verification failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic checkWord(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("Verification failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic clearSlots();
    for (int i = 0; i < NumIn; i++) begin
      pend[i]     = 1'b0;
      slotWen[i]  = 1'b0;
      slotAddr[i] = '0;
      slotBe[i]   = '0;
      slotData[i] = '0;
      slotExp[i]  = '0;
      slotFile[i] = 1'b0;
    end
  endtask

  ////////////////////////////////////////
  // one batch, cycle by cycle
  ////////////////////////////////////////

  // entered right after a rising edge, leaves after one
  task automatic runBatch();
    bit    busyNext [NumOut];
    bit    granted  [NumIn];
    int    win;
    int    idx;
    int    w;
    bit    going;
    logic  expV;
    going = 1'b1;
    while (going) begin
      #2;
      for (int i = 0; i < NumIn; i++) begin
        req[i]   = pend[i];
        addr[i]  = slotAddr[i];
        wen[i]   = slotWen[i];
        wdata[i] = slotData[i];
        be[i]    = slotBe[i];
      end
      // sample late in the cycle
      #16;
      for (int i = 0; i < NumIn; i++) begin
        granted[i] = 1'b0;
      end
      // first pending requester at or after the pointer, if bank ready
      for (int b = 0; b < NumOut; b++) begin
        busyNext[b] = 1'b0;
        win = -1;
        if (!bankBusy[b]) begin
          for (int k = 0; k < NumIn; k++) begin
            idx = (rrPtr[b] + k) % NumIn;
            if (win < 0 && pend[idx] && bankOf(slotAddr[idx]) == b) begin
              win = idx;
            end
          end
        end
        if (win >= 0) begin
          granted[win] = 1'b1;
          rrPtr[b] = (win + 1) % NumIn;
        end
      end
      for (int i = 0; i < NumIn; i++) begin
        checkBit($sformatf("gnt_o[%0d]", i), gnt[i], granted[i]);
        expV = prevGnt[i] && (!prevWen[i] || RespOn[i]);
        checkBit($sformatf("vld_o[%0d]", i), vld[i], expV);
        if (prevGnt[i] && !prevWen[i]) begin
          checkWord($sformatf("rdata_o[%0d]", i), rdata[i], prevExp[i]);
        end
      end
      // apply this cycle's handshakes to the model
      for (int i = 0; i < NumIn; i++) begin
        if (granted[i]) begin
          w = wordOf(slotAddr[i]);
          if (slotWen[i]) begin
            refMem[w] = mergeBytes(refMem[w], slotData[i], slotBe[i]);
            // partial store blocks its bank next cycle
            if (slotBe[i] != '1) begin
              busyNext[bankOf(slotAddr[i])] = 1'b1;
            end
          end else begin
            prevExp[i] = slotFile[i] ? slotExp[i] : refMem[w];
          end
          pend[i] = 1'b0;
        end
        prevGnt[i] = granted[i];
        prevWen[i] = slotWen[i];
      end
      going = 1'b0;
      for (int b = 0; b < NumOut; b++) begin
        bankBusy[b] = busyNext[b];
      end
      for (int i = 0; i < NumIn; i++) begin
        if (pend[i] || prevGnt[i]) begin
          going = 1'b1;
        end
      end
      @(posedge clk);
    end
  endtask

  ////////////////////////////////////////
  // run limit
  ////////////////////////////////////////

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycleLimit > 0 && cycles > cycleLimit) begin
      $display("timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("Verification failed");
      $fatal(1, "timeout");
    end
  end

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    int               fd;
    string            line;
    int               n;
    int               i;
    int               b;
    int               w;
    bit               hit;
    int               tBatch;
    int               tInit;
    int               tOp;
    logic [AddrW-1:0] tAddr;
    byteEn_t          tBe;
    word_t            tData;
    word_t            tExp;
    req        = '0;
    addr       = '0;
    wen        = '0;
    wdata      = '0;
    be         = '0;
    cycles     = 0;
    cycleLimit = 0;
    lcgState   = 32'd71710;
    nLines     = 0;
    clearSlots();
    for (int k = 0; k < NumOut; k++) begin
      rrPtr[k]    = 0;
      bankBusy[k] = 1'b0;
    end
    for (int k = 0; k < NumIn; k++) begin
      prevGnt[k] = 1'b0;
      prevWen[k] = 1'b0;
      prevExp[k] = '0;
    end

    fd = $fopen("tb/tcdm_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open the vectors file tb/tcdm_vectors.txt");
      $display("Verification failed");
      $fatal(1, "no vectors");
    end
    while (!$feof(fd) && nLines < MaxLines) begin
      line = "";
      n = $fgets(line, fd);
      n = $sscanf(line, "%d %d %d %h %h %h %h", tBatch, tInit, tOp, tAddr, tBe, tData, tExp);
      // comment and blank lines do not scan
      if (n == 7) begin
        vBatch[nLines] = tBatch;
        vInit[nLines]  = tInit;
        vOp[nLines]    = tOp;
        vAddr[nLines]  = tAddr;
        vBe[nLines]    = tBe;
        vData[nLines]  = tData;
        vExp[nLines]   = tExp;
        nLines++;
      end
    end
    $fclose(fd);

    // every transaction gets 20 cycles, on top of reset
    cycleLimit = 20 * (nLines + NumWords + RandBatches * NumIn) + ResetCycles;

    @(negedge rst);
    @(posedge clk);

    // directed batches
    i = 0;
    while (i < nLines) begin
      clearSlots();
      b = vBatch[i];
      while (i < nLines && vBatch[i] == b) begin
        pend[vInit[i]]     = 1'b1;
        slotWen[vInit[i]]  = (vOp[i] != 0);
        slotAddr[vInit[i]] = vAddr[i];
        slotBe[vInit[i]]   = vBe[i];
        slotData[vInit[i]] = vData[i];
        slotExp[vInit[i]]  = vExp[i];
        slotFile[vInit[i]] = 1'b1;
        i++;
      end
      runBatch();
    end

    // fill every word, pattern from the whole word address
    for (int r = 0; r < NumWords / NumIn; r++) begin
      clearSlots();
      for (int j = 0; j < NumIn; j++) begin
        w = r * NumIn + j;
        pend[j]     = 1'b1;
        slotWen[j]  = 1'b1;
        slotAddr[j] = AddrW'(w << 2);
        slotBe[j]   = '1;
        slotData[j] = word_t'(w) * 32'h9e3779b1 ^ 32'h5a5a0000;
      end
      runBatch();
    end

    // random batches, distinct words inside a batch
    for (int r = 0; r < RandBatches; r++) begin
      clearSlots();
      for (int j = 0; j < NumIn; j++) begin
        if (j == r % NumIn || nextRand() % 4 != 0) begin
          do begin
            w = int'(nextRand() % NumWords);
            hit = 1'b0;
            for (int k = 0; k < j; k++) begin
              if (pend[k] && wordOf(slotAddr[k]) == w) begin
                hit = 1'b1;
              end
            end
          end while (hit);
          pend[j]     = 1'b1;
          slotWen[j]  = (nextRand() % 2) != 0;
          slotAddr[j] = AddrW'(w << 2);
          slotBe[j]   = (nextRand() % 4 == 0) ? byteEn_t'(nextRand() % 15 + 1) : '1;
          slotData[j] = (word_t'(nextRand() % 65536) << 16) | word_t'(nextRand() % 65536);
        end
      end
      runBatch();
    end

    $display("Verification passed");
    $finish;
  end

endmodule

//--- tb/tcdm_sva.sv
/*
  Protocol assertions for the TCDM crossbar.
  Bound into every tcdm_xbar instance from the testbench top.
*/
`timescale 1ns/1ns
`include "tcdm_config.svh"

module tcdm_sva
  import tcdm_req_pkg::*;
(
  input logic                                         clk_i,
  input logic                                         rst_i,
  // initiator side grants and bank selects
  input logic     [`TCDM_NUM_IN-1:0]                    initGnt_i,
  input bankSel_t [`TCDM_NUM_IN-1:0]                    bankSel_i,
  // bank side handshake
  input logic     [`TCDM_NUM_OUT-1:0]                   bankReq_i,
  input logic     [`TCDM_NUM_OUT-1:0]                   bankAck_i,
  input bankReq_t [`TCDM_NUM_OUT-1:0]                   bankData_i,
  input logic     [`TCDM_NUM_IN-1:0]                    vld_i
);

  // granted initiators sorted by the bank they address
  logic [`TCDM_NUM_OUT-1:0][`TCDM_NUM_IN-1:0] gntByBank;

  always_comb begin
    for (int k = 0; k < `TCDM_NUM_OUT; k++) begin
      for (int j = 0; j < `TCDM_NUM_IN; j++) begin
        gntByBank[k][j] = initGnt_i[j] && (bankSel_i[j] == bankSel_t'(k));
      end
    end
  end

  for (genvar k = 0; k < `TCDM_NUM_OUT; k++) begin : gen_bank_chk
    // one winner per bank, and only with a bank handshake
    oneGrant: assert property (@(posedge clk_i) disable iff (rst_i)
      $onehot0(gntByBank[k]) && ((|gntByBank[k]) == (bankReq_i[k] && bankAck_i[k])))
      else $error("bank %0d grants do not match its handshake", k);

    // refused request stays put
    holdReq: assert property (@(posedge clk_i) disable iff (rst_i)
      (bankReq_i[k] && !bankAck_i[k]) |=> (bankReq_i[k] && $stable(bankData_i[k])))
      else $error("bank %0d request changed while refused", k);
  end

  for (genvar j = 0; j < `TCDM_NUM_IN; j++) begin : gen_init_chk
    // a response needs this initiator's grant one cycle earlier
    vldCause: assert property (@(posedge clk_i) disable iff (rst_i)
      vld_i[j] |-> $past(initGnt_i[j]))
      else $error("initiator %0d vld raised without a grant in the cycle before", j);
  end

endmodule

//--- tb/tb_clkgen.sv
/*
  Clock and reset source for the TCDM testbench.
  Free-running clock, reset released a little after a rising edge.
*/
`timescale 1ns/1ns

module tb_clkgen #(
  parameter int PeriodNs    = 20,
  parameter int ResetCycles = 16
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // reset held for a fixed number of edges
  initial begin
    rst_o = 1'b1;
    repeat (ResetCycles) @(posedge clk_o);
    #2;
    rst_o = 1'b0;
  end

endmodule

//--- rtl/tcdm_subsystem.sv
/*
  Top level of the shared TCDM.
  Four initiators reach four word-interleaved banks through the
  interconnect. Instance and wiring only.
*/
`timescale 1ns/1ns
`include "tcdm_config.svh"

module tcdm_subsystem
  import tcdm_req_pkg::*;
  import tcdm_resp_pkg::*;
(
  input  logic                                          clk_i,
  input  logic                                          rst_i,
  input  logic    [`TCDM_NUM_IN-1:0]                    req_i,
  input  logic    [`TCDM_NUM_IN-1:0][`TCDM_ADDR_WIDTH-1:0] addr_i,
  input  logic    [`TCDM_NUM_IN-1:0]                    wen_i,
  input  word_t   [`TCDM_NUM_IN-1:0]                    wdata_i,
  input  byteEn_t [`TCDM_NUM_IN-1:0]                    be_i,
  output logic    [`TCDM_NUM_IN-1:0]                    gnt_o,
  output logic    [`TCDM_NUM_IN-1:0]                    vld_o,
  output word_t   [`TCDM_NUM_IN-1:0]                    rdata_o
);

  localparam int NumOut = `TCDM_NUM_OUT;

  // bank-side wiring
  logic     [NumOut-1:0] bankReq;
  bankReq_t [NumOut-1:0] bankData;
  logic     [NumOut-1:0] bankGnt;
  word_t    [NumOut-1:0] bankRdata;

  tcdm_interconnect i_tcdm_interconnect (
    .clk_i       ( clk_i     ),
    .rst_i       ( rst_i     ),
    .req_i       ( req_i     ),
    .addr_i      ( addr_i    ),
    .wen_i       ( wen_i     ),
    .wdata_i     ( wdata_i   ),
    .be_i        ( be_i      ),
    .gnt_o       ( gnt_o     ),
    .vld_o       ( vld_o     ),
    .rdata_o     ( rdata_o   ),
    .bankReq_o   ( bankReq   ),
    .bankData_o  ( bankData  ),
    .bankGnt_i   ( bankGnt   ),
    .bankRdata_i ( bankRdata )
  );

  for (genvar k = 0; k < NumOut; k++) begin : gen_bank
    tcdm_bank i_tcdm_bank (
      .clk_i   ( clk_i        ),
      .rst_i   ( rst_i        ),
      .req_i   ( bankReq[k]   ),
      .data_i  ( bankData[k]  ),
      .gnt_o   ( bankGnt[k]   ),
      .rdata_o ( bankRdata[k] )
    );
  end

endmodule

//--- rtl/tcdm_bank.sv
/*
  One single-port TCDM bank storing whole words.
  Reads and full-word writes take one cycle. A write with partial byte
  enables is merged with the old word in the following cycle, and the
  bank refuses new requests while it does so.
*/
`timescale 1ns/1ns
`include "tcdm_config.svh"

module tcdm_bank
  import tcdm_req_pkg::*;
  import tcdm_resp_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     req_i,
  input  bankReq_t data_i,
  output logic     gnt_o,
  output word_t    rdata_o
);

  localparam int NumWords = 2**`TCDM_ADDR_MEM_WIDTH;
  localparam int BeWidth  = `TCDM_DATA_WIDTH/8;

  word_t    mem [NumWords];
  word_t    rdataQ;
  // pending merge of a partial store
  logic     rmwQ;
  memAddr_t rmwAddrQ;
  byteEn_t  rmwBeQ;
  word_t    rmwDataQ;
  word_t    merged;
  logic     hsk;
  logic     partial;

  // busy only during the merge cycle
  assign gnt_o   = ~rmwQ;
  assign hsk     = req_i & gnt_o;
  assign partial = data_i.wen & (data_i.be != '1);
  assign rdata_o = rdataQ;

  // old word with the enabled lanes replaced
  always_comb begin
    merged = mem[rmwAddrQ];
    for (int b = 0; b < BeWidth; b++) begin
      if (rmwBeQ[b]) begin
        merged[8*b +: 8] = rmwDataQ[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rmwQ <= 1'b0;
    end else begin
      rmwQ <= hsk & partial;
    end
  end

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rmwQ) begin
      mem[rmwAddrQ] <= merged;
    end
    if (hsk) begin
      if (!data_i.wen) begin
        rdataQ <= mem[data_i.addr];
      end else if (!partial) begin
        mem[data_i.addr] <= data_i.wdata;
      end
    end
    // capture partial store for the merge cycle
    if (hsk && partial) begin
      rmwAddrQ <= data_i.addr;
      rmwBeQ   <= data_i.be;
      rmwDataQ <= data_i.wdata;
    end
  end

endmodule

//--- rtl/tcdm_interconnect.sv
/*
  Initiator-facing TCDM interconnect.
  Splits each byte address into bank select and in-bank word address,
  packs the request for the banks and routes it through the crossbar.
*/
`timescale 1ns/1ns
`include "tcdm_config.svh"

module tcdm_interconnect
  import tcdm_req_pkg::*;
  import tcdm_resp_pkg::*;
(
  input  logic                                           clk_i,
  input  logic                                           rst_i,
  // initiator side
  input  logic     [`TCDM_NUM_IN-1:0]                    req_i,
  input  logic     [`TCDM_NUM_IN-1:0][`TCDM_ADDR_WIDTH-1:0] addr_i,
  input  logic     [`TCDM_NUM_IN-1:0]                    wen_i,
  input  word_t    [`TCDM_NUM_IN-1:0]                    wdata_i,
  input  byteEn_t  [`TCDM_NUM_IN-1:0]                    be_i,
  output logic     [`TCDM_NUM_IN-1:0]                    gnt_o,
  output logic     [`TCDM_NUM_IN-1:0]                    vld_o,
  output word_t    [`TCDM_NUM_IN-1:0]                    rdata_o,
  // bank side
  output logic     [`TCDM_NUM_OUT-1:0]                   bankReq_o,
  output bankReq_t [`TCDM_NUM_OUT-1:0]                   bankData_o,
  input  logic     [`TCDM_NUM_OUT-1:0]                   bankGnt_i,
  input  word_t    [`TCDM_NUM_OUT-1:0]                   bankRdata_i
);

  localparam int NumIn        = `TCDM_NUM_IN;
  localparam int NumOut       = `TCDM_NUM_OUT;
  localparam int NumOutLog2   = $clog2(NumOut);
  localparam int ByteOffWidth = $clog2(`TCDM_DATA_WIDTH/8);
  localparam int AddrMemWidth = `TCDM_ADDR_MEM_WIDTH;

  bankSel_t [NumIn-1:0] bankSel;
  bankReq_t [NumIn-1:0] reqData;

  // byte offset dropped, bank bits next, word index above
  for (genvar j = 0; j < NumIn; j++) begin : gen_split
    assign bankSel[j] = addr_i[j][ByteOffWidth +: NumOutLog2];
    assign reqData[j] = '{
      wen:   wen_i[j],
      be:    be_i[j],
      addr:  addr_i[j][ByteOffWidth+NumOutLog2 +: AddrMemWidth],
      wdata: wdata_i[j]
    };
  end

  tcdm_xbar i_tcdm_xbar (
    .clk_i     ( clk_i       ),
    .rst_i     ( rst_i       ),
    .req_i     ( req_i       ),
    .bankSel_i ( bankSel     ),
    .wen_i     ( wen_i       ),
    .data_i    ( reqData     ),
    .gnt_o     ( gnt_o       ),
    .vld_o     ( vld_o       ),
    .rdata_o   ( rdata_o     ),
    .req_o     ( bankReq_o   ),
    .gnt_i     ( bankGnt_i   ),
    .data_o    ( bankData_o  ),
    .rdata_i   ( bankRdata_i )
  );

  ////////////////////////////////////////
  // configuration checks
  ////////////////////////////////////////

  initial begin
    assert (ByteOffWidth + NumOutLog2 + AddrMemWidth <= `TCDM_ADDR_WIDTH)
      else $fatal(1, "address too narrow for this bank configuration");
    assert (NumOut >= NumIn)
      else $fatal(1, "fewer banks than initiators is not supported");
    assert (2**NumOutLog2 == NumOut)
      else $fatal(1, "bank count must be a power of two");
  end

endmodule

//--- rtl/tcdm_xbar.sv
/*
  Full crossbar between the initiators and the banks.
  One round-robin arbiter per bank picks the initiator served there.
  The winner and the access kind are kept for one cycle to steer the
  read word and vld back to the right initiator.
*/
`timescale 1ns/1ns
`include "tcdm_config.svh"

module tcdm_xbar
  import tcdm_req_pkg::*;
  import tcdm_resp_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_i,
  // initiator side
  input  logic     [`TCDM_NUM_IN-1:0]  req_i,
  input  bankSel_t [`TCDM_NUM_IN-1:0]  bankSel_i,
  input  logic     [`TCDM_NUM_IN-1:0]  wen_i,
  input  bankReq_t [`TCDM_NUM_IN-1:0]  data_i,
  output logic     [`TCDM_NUM_IN-1:0]  gnt_o,
  output logic     [`TCDM_NUM_IN-1:0]  vld_o,
  output word_t    [`TCDM_NUM_IN-1:0]  rdata_o,
  // bank side
  output logic     [`TCDM_NUM_OUT-1:0] req_o,
  input  logic     [`TCDM_NUM_OUT-1:0] gnt_i,
  output bankReq_t [`TCDM_NUM_OUT-1:0] data_o,
  input  word_t    [`TCDM_NUM_OUT-1:0] rdata_i
);

  localparam int NumIn  = `TCDM_NUM_IN;
  localparam int NumOut = `TCDM_NUM_OUT;
  localparam logic [NumIn-1:0] WriteRespOn = `TCDM_WRITE_RESP_ON;

  // per bank, which initiators want it and which got it
  logic     [NumOut-1:0][NumIn-1:0] bankReq;
  logic     [NumOut-1:0][NumIn-1:0] bankGnt;
  initIdx_t [NumOut-1:0]            arbIdx;
  // response steering, one cycle behind the handshake
  logic     [NumOut-1:0]            respVldQ;
  logic     [NumOut-1:0]            respWenQ;
  initIdx_t [NumOut-1:0]            respIdxQ;

  ////////////////////////////////////////
  // request path
  ////////////////////////////////////////

  // decode bank select into per-bank vectors
  always_comb begin
    for (int k = 0; k < NumOut; k++) begin
      for (int j = 0; j < NumIn; j++) begin
        bankReq[k][j] = req_i[j] && (bankSel_i[j] == bankSel_t'(k));
      end
    end
  end

  // an initiator hits one bank, so OR-ing is safe
  always_comb begin
    gnt_o = '0;
    for (int k = 0; k < NumOut; k++) begin
      for (int j = 0; j < NumIn; j++) begin
        gnt_o[j] = gnt_o[j] | bankGnt[k][j];
      end
    end
  end

  for (genvar k = 0; k < NumOut; k++) begin : gen_arb
    rr_arbiter i_rr_arbiter (
      .clk_i  ( clk_i      ),
      .rst_i  ( rst_i      ),
      .req_i  ( bankReq[k] ),
      .data_i ( data_i     ),
      .gnt_o  ( bankGnt[k] ),
      .req_o  ( req_o[k]   ),
      .data_o ( data_o[k]  ),
      .idx_o  ( arbIdx[k]  ),
      .gnt_i  ( gnt_i[k]   )
    );
  end

  ////////////////////////////////////////
  // response path
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      respVldQ <= '0;
    end else begin
      respVldQ <= req_o & gnt_i;
    end
  end

  // steering info, only looked at with respVldQ
  always_ff @(posedge clk_i) begin
    for (int k = 0; k < NumOut; k++) begin
      respIdxQ[k] <= arbIdx[k];
      respWenQ[k] <= wen_i[arbIdx[k]];
    end
  end

  always_comb begin
    vld_o   = '0;
    rdata_o = '0;
    for (int k = 0; k < NumOut; k++) begin
      if (respVldQ[k]) begin
        // stores answer only where enabled
        if (!respWenQ[k] || WriteRespOn[respIdxQ[k]]) begin
          vld_o[respIdxQ[k]] = 1'b1;
        end
        rdata_o[respIdxQ[k]] = rdata_i[k];
      end
    end
  end

endmodule

//--- rtl/rr_arbiter.sv
/*
  Round-robin arbiter in front of one bank.
  Picks one of the initiator requests, forwards its payload and grants it
  in the cycle the bank accepts. A refused choice stays locked until the
  bank takes it.
*/
`timescale 1ns/1ns
`include "tcdm_config.svh"

module rr_arbiter
  import tcdm_req_pkg::*;
  import tcdm_resp_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_i,
  // initiator side
  input  logic     [`TCDM_NUM_IN-1:0] req_i,
  input  bankReq_t [`TCDM_NUM_IN-1:0] data_i,
  output logic     [`TCDM_NUM_IN-1:0] gnt_o,
  // bank side
  output logic                        req_o,
  output bankReq_t                    data_o,
  output initIdx_t                    idx_o,
  input  logic                        gnt_i
);

  localparam int NumIn = `TCDM_NUM_IN;

  // highest priority initiator
  initIdx_t rrQ;
  // choice held while the bank refuses it
  logic     lockQ;
  initIdx_t lockIdxQ;
  initIdx_t winner;
  logic     hsk;

  ////////////////////////////////////////
  // selection
  ////////////////////////////////////////

  always_comb begin
    winner = rrQ;
    if (lockQ && req_i[lockIdxQ]) begin
      winner = lockIdxQ;
    end else begin
      // walk down so the nearest requester at or after rrQ wins last
      for (int k = NumIn - 1; k >= 0; k--) begin
        if (req_i[(int'(rrQ) + k) % NumIn]) begin
          winner = initIdx_t'((int'(rrQ) + k) % NumIn);
        end
      end
    end
  end

  assign req_o  = |req_i;
  assign data_o = data_i[winner];
  assign idx_o  = winner;
  assign hsk    = req_o & gnt_i;

  // one-hot grant back to the winner only
  always_comb begin
    gnt_o         = '0;
    gnt_o[winner] = hsk;
  end

  ////////////////////////////////////////
  // pointer and lock
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rrQ      <= '0;
      lockQ    <= 1'b0;
      lockIdxQ <= '0;
    end else begin
      lockQ    <= req_o & ~gnt_i;
      lockIdxQ <= winner;
      // next round starts just past the winner
      if (hsk) begin
        rrQ <= initIdx_t'((int'(winner) + 1) % NumIn);
      end
    end
  end

endmodule

//--- rtl/tcdm_resp_pkg.sv
/*
  Response-side types of the TCDM interconnect.
  Imported wherever read words or initiator indices travel back.
*/
`include "tcdm_config.svh"

package tcdm_resp_pkg;

  // one memory word
  typedef logic [`TCDM_DATA_WIDTH-1:0] word_t;

  // which initiator a response belongs to
  typedef logic [$clog2(`TCDM_NUM_IN)-1:0] initIdx_t;

endpackage

//--- rtl/tcdm_req_pkg.sv
/*
  Request-side types of the TCDM interconnect.
  Imported by the modules that split initiator addresses, route requests
  to the banks or decode them inside a bank.
*/
`include "tcdm_config.svh"

package tcdm_req_pkg;

  // bank index, low word-address bits
  typedef logic [$clog2(`TCDM_NUM_OUT)-1:0] bankSel_t;

  // word index inside a single bank
  typedef logic [`TCDM_ADDR_MEM_WIDTH-1:0] memAddr_t;

  // one enable per byte lane
  typedef logic [`TCDM_DATA_WIDTH/8-1:0] byteEn_t;

  // everything a bank needs for one access
  // wen high means store
  typedef struct packed {
    logic                        wen;
    byteEn_t                     be;
    memAddr_t                    addr;
    logic [`TCDM_DATA_WIDTH-1:0] wdata;
  } bankReq_t;

endpackage

//--- rtl/tcdm_config.svh
/*
  Sizes of the shared TCDM subsystem.
  Included by the request package and by every RTL module that needs a
  size. The testbench includes it for its reference memory.
*/
`ifndef TCDM_CONFIG_SVH
`define TCDM_CONFIG_SVH

////////////////////////////////////////
// cluster shape
////////////////////////////////////////

// initiator ports
`define TCDM_NUM_IN 4
// memory banks, power of two, not fewer than initiators
`define TCDM_NUM_OUT 4

////////////////////////////////////////
// address and data
////////////////////////////////////////

// byte address on the initiator side
`define TCDM_ADDR_WIDTH 16
`define TCDM_DATA_WIDTH 32
// word address bits inside one bank
`define TCDM_ADDR_MEM_WIDTH 6

// one bit per initiator, set bit means writes also pulse vld_o
`define TCDM_WRITE_RESP_ON 4'b0111

`endif
